//--- Bender.yml
package:
  name: decode_stage

sources:
  - rv_decode_pkg.sv
  - regfile.sv
  - imm_gen.sv
  - main_decoder.sv
  - id_ex_reg.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv

//--- decode_stage.sv
module decode_stage import rv_decode_pkg::*; #(
   parameter int REG_COUNT = 32  // 16 for RV32E
) (
   input  logic            clk_i,
   input  logic            reset_i,
   input  instr_u          instr_i,
   input  logic [XLEN-1:0] pc_i,
   input  logic            wb_en_i,
   input  logic [4:0]      wb_rd_i,
   input  logic [XLEN-1:0] wb_data_i,
   input  logic            busywait_i,
   input  logic            flush_i,
   output logic [XLEN-1:0] pc_o,
   output logic [XLEN-1:0] rs1_value_o,
   output logic [XLEN-1:0] rs2_value_o,
   output logic [XLEN-1:0] imm_o,
   output logic            alu_op1_sel_o,
   output logic            alu_op2_sel_o,
   output mem_op_e         mem_op_o,
   output wb_sel_e         wb_sel_o,
   output logic            reg_wr_en_o,
   output logic [4:0]      rd_o,
   output logic [4:0]      rs1_o,
   output logic [4:0]      rs2_o,
   output logic [2:0]      funct3_o,
   output logic [6:0]      funct7_o,
   output logic            is_load_o,
   output logic            is_store_o,
   output logic            is_branch_o,
   output logic            is_jump_o,
   output ex_op_e          ex_op_o,
   output logic            stall_o
);

   logic [XLEN-1:0] rs1_value;
   logic [XLEN-1:0] rs2_value;
   logic [XLEN-1:0] imm;
   imm_fmt_e        imm_fmt;
   logic            alu_op1_sel;
   logic            alu_op2_sel;
   mem_op_e         mem_op;
   wb_sel_e         wb_sel;
   logic            reg_wr_en;
   ex_op_e          ex_op;
   logic            is_load;
   logic            is_store;
   logic            is_branch;
   logic            is_jump;

   ////////////////////
   // Operand path
   ////////////////////

   regfile #(
      .REG_COUNT (REG_COUNT)
   ) u_regfile (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .wr_en_i    (wb_en_i),  // Write-back keeps writing during busywait
      .wr_addr_i  (wb_rd_i),
      .wr_data_i  (wb_data_i),
      .rs1_addr_i (instr_i.r.rs1),
      .rs2_addr_i (instr_i.r.rs2),
      .rs1_data_o (rs1_value),
      .rs2_data_o (rs2_value)
   );

   imm_gen u_imm_gen (
      .instr_i   (instr_i),
      .imm_fmt_i (imm_fmt),
      .imm_o     (imm)
   );

   ////////////////////
   // Control path
   ////////////////////

   main_decoder u_main_decoder (
      .instr_i       (instr_i),
      .imm_fmt_o     (imm_fmt),
      .alu_op1_sel_o (alu_op1_sel),
      .alu_op2_sel_o (alu_op2_sel),
      .mem_op_o      (mem_op),
      .wb_sel_o      (wb_sel),
      .reg_wr_en_o   (reg_wr_en),
      .ex_op_o       (ex_op),
      .is_load_o     (is_load),
      .is_store_o    (is_store),
      .is_branch_o   (is_branch),
      .is_jump_o     (is_jump)
   );

   // ID/EX register and hazard check
   id_ex_reg #(
      .REG_COUNT (REG_COUNT)
   ) u_id_ex_reg (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .busywait_i    (busywait_i),
      .flush_i       (flush_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .rs1_value_i   (rs1_value),
      .rs2_value_i   (rs2_value),
      .imm_i         (imm),
      .alu_op1_sel_i (alu_op1_sel),
      .alu_op2_sel_i (alu_op2_sel),
      .mem_op_i      (mem_op),
      .wb_sel_i      (wb_sel),
      .reg_wr_en_i   (reg_wr_en),
      .ex_op_i       (ex_op),
      .is_load_i     (is_load),
      .is_store_i    (is_store),
      .is_branch_i   (is_branch),
      .is_jump_i     (is_jump),
      .pc_o          (pc_o),
      .rs1_value_o   (rs1_value_o),
      .rs2_value_o   (rs2_value_o),
      .imm_o         (imm_o),
      .alu_op1_sel_o (alu_op1_sel_o),
      .alu_op2_sel_o (alu_op2_sel_o),
      .mem_op_o      (mem_op_o),
      .wb_sel_o      (wb_sel_o),
      .reg_wr_en_o   (reg_wr_en_o),
      .rd_o          (rd_o),
      .rs1_o         (rs1_o),
      .rs2_o         (rs2_o),
      .funct3_o      (funct3_o),
      .funct7_o      (funct7_o),
      .is_load_o     (is_load_o),
      .is_store_o    (is_store_o),
      .is_branch_o   (is_branch_o),
      .is_jump_o     (is_jump_o),
      .ex_op_o       (ex_op_o),
      .stall_o       (stall_o)
   );

endmodule

//--- id_ex_reg.sv
module id_ex_reg import rv_decode_pkg::*; #(
   parameter int REG_COUNT = 32
) (
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic            busywait_i,
   input  logic            flush_i,
   input  instr_u          instr_i,
   input  logic [XLEN-1:0] pc_i,
   input  logic [XLEN-1:0] rs1_value_i,
   input  logic [XLEN-1:0] rs2_value_i,
   input  logic [XLEN-1:0] imm_i,
   input  logic            alu_op1_sel_i,
   input  logic            alu_op2_sel_i,
   input  mem_op_e         mem_op_i,
   input  wb_sel_e         wb_sel_i,
   input  logic            reg_wr_en_i,
   input  ex_op_e          ex_op_i,
   input  logic            is_load_i,
   input  logic            is_store_i,
   input  logic            is_branch_i,
   input  logic            is_jump_i,
   output logic [XLEN-1:0] pc_o,
   output logic [XLEN-1:0] rs1_value_o,
   output logic [XLEN-1:0] rs2_value_o,
   output logic [XLEN-1:0] imm_o,
   output logic            alu_op1_sel_o,
   output logic            alu_op2_sel_o,
   output mem_op_e         mem_op_o,
   output wb_sel_e         wb_sel_o,
   output logic            reg_wr_en_o,
   output logic [4:0]      rd_o,
   output logic [4:0]      rs1_o,
   output logic [4:0]      rs2_o,
   output logic [2:0]      funct3_o,
   output logic [6:0]      funct7_o,
   output logic            is_load_o,
   output logic            is_store_o,
   output logic            is_branch_o,
   output logic            is_jump_o,
   output ex_op_e          ex_op_o,
   output logic            stall_o
);

   logic load_rd_live;
   logic bubble;

   ////////////////////
   // Load-use hazard
   ////////////////////

   // Load in execute whose result is actually written somewhere
   assign load_rd_live = is_load_o && (rd_o != 5'd0) && (int'(rd_o) < REG_COUNT);

   assign stall_o = load_rd_live &&
                    ((rd_o == instr_i.r.rs1) || (rd_o == instr_i.r.rs2));

   assign bubble = flush_i || stall_o;

   ////////////////////
   // Pipeline register
   ////////////////////

   // Reset, then hold on busywait, then bubble, then load
   always_ff @(posedge clk_i) begin
      if (reset_i || (!busywait_i && bubble)) begin
         pc_o          <= '0;
         rs1_value_o   <= '0;
         rs2_value_o   <= '0;
         imm_o         <= '0;
         alu_op1_sel_o <= 1'b0;
         alu_op2_sel_o <= 1'b0;
         mem_op_o      <= MEM_NONE;
         wb_sel_o      <= WB_ALU;
         reg_wr_en_o   <= 1'b0;
         rd_o          <= '0;
         rs1_o         <= '0;
         rs2_o         <= '0;
         funct3_o      <= '0;
         funct7_o      <= '0;
         is_load_o     <= 1'b0;
         is_store_o    <= 1'b0;
         is_branch_o   <= 1'b0;
         is_jump_o     <= 1'b0;
         ex_op_o       <= EX_ADD;
      end else if (!busywait_i) begin
         pc_o          <= pc_i;
         rs1_value_o   <= rs1_value_i;
         rs2_value_o   <= rs2_value_i;
         imm_o         <= imm_i;
         alu_op1_sel_o <= alu_op1_sel_i;
         alu_op2_sel_o <= alu_op2_sel_i;
         mem_op_o      <= mem_op_i;
         wb_sel_o      <= wb_sel_i;
         reg_wr_en_o   <= reg_wr_en_i;
         rd_o          <= instr_i.r.rd;  // Register numbers from the word itself
         rs1_o         <= instr_i.r.rs1;
         rs2_o         <= instr_i.r.rs2;
         funct3_o      <= instr_i.r.funct3;
         funct7_o      <= instr_i.r.funct7;
         is_load_o     <= is_load_i;
         is_store_o    <= is_store_i;
         is_branch_o   <= is_branch_i;
         is_jump_o     <= is_jump_i;
         ex_op_o       <= ex_op_i;
      end
   end

endmodule

//--- imm_gen.sv
module imm_gen import rv_decode_pkg::*; (
   input  instr_u          instr_i,
   input  imm_fmt_e        imm_fmt_i,
   output logic [XLEN-1:0] imm_o
);

   logic [31:0] w;
   logic        sign;

   assign w    = instr_i.raw;
   assign sign = w[31];  // Every signed format takes its sign here

   // Bit order per the base ISA formats
   always_comb begin
      unique case (imm_fmt_i)
         IMM_I: begin
            imm_o = {{(XLEN-12){sign}}, w[31:20]};
         end
         IMM_S: begin
            imm_o = {{(XLEN-12){sign}}, w[31:25], w[11:7]};
         end
         IMM_B: begin
            // Halfword offset, bit 0 always clear
            imm_o = {{(XLEN-13){sign}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         end
         IMM_U: begin
            imm_o = {w[31:12], 12'b0};  // Upper 20 bits, no extension
         end
         IMM_J: begin
            imm_o = {{(XLEN-21){sign}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         end
         IMM_NONE: begin
            imm_o = '0;
         end
         default: begin
            imm_o = '0;
         end
      endcase
   end

endmodule

//--- main_decoder.sv
module main_decoder import rv_decode_pkg::*; (
   input  instr_u   instr_i,
   output imm_fmt_e imm_fmt_o,
   output logic     alu_op1_sel_o,  // 1 selects PC
   output logic     alu_op2_sel_o,  // 1 selects immediate
   output mem_op_e  mem_op_o,
   output wb_sel_e  wb_sel_o,
   output logic     reg_wr_en_o,
   output ex_op_e   ex_op_o,
   output logic     is_load_o,
   output logic     is_store_o,
   output logic     is_branch_o,
   output logic     is_jump_o
);

   opcode_e    opcode;
   logic [2:0] funct3;

   assign opcode = opcode_e'(instr_i.r.opcode[6:2]);
   assign funct3 = instr_i.r.funct3;

   always_comb begin
      // Bubble values unless the opcode is known
      imm_fmt_o     = IMM_NONE;
      alu_op1_sel_o = 1'b0;
      alu_op2_sel_o = 1'b0;
      mem_op_o      = MEM_NONE;
      wb_sel_o      = WB_ALU;
      reg_wr_en_o   = 1'b0;
      ex_op_o       = EX_ADD;
      is_load_o     = 1'b0;
      is_store_o    = 1'b0;
      is_branch_o   = 1'b0;
      is_jump_o     = 1'b0;

      case (opcode)
         LOAD: begin
            imm_fmt_o     = IMM_I;
            alu_op2_sel_o = 1'b1;
            wb_sel_o      = WB_MEM;
            reg_wr_en_o   = 1'b1;
            is_load_o     = 1'b1;
            case (funct3)  // Access size and signedness
               3'b000:  mem_op_o = LB;
               3'b001:  mem_op_o = LH;
               3'b010:  mem_op_o = LW;
               3'b100:  mem_op_o = LBU;
               3'b101:  mem_op_o = LHU;
               default: mem_op_o = MEM_NONE;
            endcase
         end
         STORE: begin
            imm_fmt_o     = IMM_S;
            alu_op2_sel_o = 1'b1;
            is_store_o    = 1'b1;
            case (funct3)
               3'b000:  mem_op_o = SB;
               3'b001:  mem_op_o = SH;
               3'b010:  mem_op_o = SW;
               default: mem_op_o = MEM_NONE;
            endcase
         end
         BRANCH: begin
            imm_fmt_o     = IMM_B;
            alu_op1_sel_o = 1'b1;  // Target from PC
            alu_op2_sel_o = 1'b1;
            ex_op_o       = EX_BRANCH;
            is_branch_o   = 1'b1;
         end
         JAL, JALR: begin
            imm_fmt_o     = (opcode == JAL) ? IMM_J : IMM_I;
            alu_op1_sel_o = (opcode == JAL);  // JALR adds to rs1
            alu_op2_sel_o = 1'b1;
            wb_sel_o      = WB_PC4;
            reg_wr_en_o   = 1'b1;
            is_jump_o     = 1'b1;
         end
         OP_IMM, OP: begin
            imm_fmt_o     = (opcode == OP) ? IMM_NONE : IMM_I;
            alu_op2_sel_o = (opcode == OP_IMM);
            reg_wr_en_o   = 1'b1;
            ex_op_o       = EX_FUNCT;
         end
         LUI: begin
            imm_fmt_o     = IMM_U;
            alu_op2_sel_o = 1'b1;
            wb_sel_o      = WB_IMM;
            reg_wr_en_o   = 1'b1;
            ex_op_o       = EX_PASS;
         end
         AUIPC: begin
            imm_fmt_o     = IMM_U;
            alu_op1_sel_o = 1'b1;
            alu_op2_sel_o = 1'b1;
            reg_wr_en_o   = 1'b1;
         end
         default: ;  // Unknown opcode stays a bubble
      endcase
   end

endmodule

//--- project.f
rv_decode_pkg.sv
regfile.sv
imm_gen.sv
main_decoder.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

//--- regfile.sv
module regfile import rv_decode_pkg::*; #(
   parameter int REG_COUNT = 32
) (
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic            wr_en_i,
   input  logic [4:0]      wr_addr_i,
   input  logic [XLEN-1:0] wr_data_i,
   input  logic [4:0]      rs1_addr_i,
   input  logic [4:0]      rs2_addr_i,
   output logic [XLEN-1:0] rs1_data_o,
   output logic [XLEN-1:0] rs2_data_o
);

   logic [XLEN-1:0] regs [REG_COUNT];

   // x0 and anything past the last register hold nothing
   function automatic logic in_range(input logic [4:0] addr);
      return (addr != 5'd0) && (int'(addr) < REG_COUNT);
   endfunction

   // Same-cycle write goes straight through to the reader
   function automatic logic [XLEN-1:0] read_reg(input logic [4:0] addr);
      logic [XLEN-1:0] data;
      if (!in_range(addr)) begin
         data = '0;
      end else if (wr_en_i && (wr_addr_i == addr)) begin
         data = wr_data_i;  // Bypass
      end else begin
         data = regs[addr];
      end
      return data;
   endfunction

   ////////////////////
   // Write port
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i && in_range(wr_addr_i)) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   ////////////////////
   // Read ports
   ////////////////////

   always_comb begin
      rs1_data_o = read_reg(rs1_addr_i);
      rs2_data_o = read_reg(rs2_addr_i);
   end

endmodule

//--- rv_decode_pkg.sv
package rv_decode_pkg;

   localparam int XLEN = 32;  // Data width

   ////////////////////
   // Opcode classes
   ////////////////////

   // Bits 6:2 of the instruction word, low two bits assumed 2'b11
   typedef enum logic [4:0] {
      LOAD   = 5'b00000,
      STORE  = 5'b01000,
      BRANCH = 5'b11000,
      JAL    = 5'b11011,
      JALR   = 5'b11001,
      OP_IMM = 5'b00100,
      OP     = 5'b01100,
      LUI    = 5'b01101,
      AUIPC  = 5'b00101
   } opcode_e;

   ////////////////////
   // Control encodings
   ////////////////////

   typedef enum logic [2:0] {
      IMM_NONE = 3'd0,  // No immediate, reads as zero
      IMM_I    = 3'd1,
      IMM_S    = 3'd2,
      IMM_B    = 3'd3,
      IMM_U    = 3'd4,
      IMM_J    = 3'd5
   } imm_fmt_e;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd2,  // Link address for jumps
      WB_IMM = 2'd3
   } wb_sel_e;

   typedef enum logic [1:0] {
      EX_ADD    = 2'd0,  // Address and PC arithmetic
      EX_BRANCH = 2'd1,  // Compare for branches
      EX_FUNCT  = 2'd2,  // Execute looks at funct3 and funct7
      EX_PASS   = 2'd3   // LUI passes the immediate
   } ex_op_e;

   // Zero is the idle code, so a cleared register means no access
   typedef enum logic [3:0] {
      MEM_NONE = 4'h0,
      LB       = 4'h1,
      LH       = 4'h2,
      LW       = 4'h3,
      LBU      = 4'h4,
      LHU      = 4'h5,
      SB       = 4'h6,
      SH       = 4'h7,
      SW       = 4'h8
   } mem_op_e;

   ////////////////////
   // Instruction word
   ////////////////////

   // Register fields for decode, flat word for immediate slicing
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      logic [31:0] raw;
   } instr_u;

endpackage

//--- tb_decode_stage.sv
module tb_decode_stage import rv_decode_pkg::*; ();

   localparam int MAX_CYCLES = 2000;  // Tests run about 1150 cycles
   localparam int RAND_COUNT = 1000;
   localparam logic [31:0] NOP = 32'h0000_0013;  // addi x0, x0, 0

   typedef struct packed {
      logic    alu1;
      logic    alu2;
      mem_op_e mem;
      wb_sel_e wb;
      logic    wr;
      ex_op_e  ex;
      logic    ld;
      logic    st;
      logic    br;
      logic    jmp;
   } ctrl_t;

   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] rs1v;
      logic [31:0] rs2v;
      logic [31:0] imm;
      ctrl_t       c;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [6:0]  f7;
   } out_t;

   logic        clk_i = 1'b0;
   logic        reset_i;
   logic [31:0] instr_i;
   logic [31:0] pc_i;
   logic        wb_en_i;
   logic [4:0]  wb_rd_i;
   logic [31:0] wb_data_i;
   logic        busywait_i;
   logic        flush_i;
   logic [31:0] pc_o;
   logic [31:0] rs1_value_o;
   logic [31:0] rs2_value_o;
   logic [31:0] imm_o;
   logic        alu_op1_sel_o;
   logic        alu_op2_sel_o;
   mem_op_e     mem_op_o;
   wb_sel_e     wb_sel_o;
   logic        reg_wr_en_o;
   logic [4:0]  rd_o;
   logic [4:0]  rs1_o;
   logic [4:0]  rs2_o;
   logic [2:0]  funct3_o;
   logic [6:0]  funct7_o;
   logic        is_load_o;
   logic        is_store_o;
   logic        is_branch_o;
   logic        is_jump_o;
   ex_op_e      ex_op_o;
   logic        stall_o;

   out_t        exp_out;           // Expected ID/EX contents
   logic [31:0] shadow [32];
   logic        model_valid = 1'b0;
   logic [31:0] next_pc = 32'h0000_1000;
   int          cycle_count = 0;
   int          error_count = 0;
   int          errors_at_start = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   decode_stage #(
      .REG_COUNT (32)
   ) dut_i (
      .clk_i (clk_i), .reset_i (reset_i), .instr_i (instr_i), .pc_i (pc_i),
      .wb_en_i (wb_en_i), .wb_rd_i (wb_rd_i), .wb_data_i (wb_data_i),
      .busywait_i (busywait_i), .flush_i (flush_i), .pc_o (pc_o),
      .rs1_value_o (rs1_value_o), .rs2_value_o (rs2_value_o), .imm_o (imm_o),
      .alu_op1_sel_o (alu_op1_sel_o), .alu_op2_sel_o (alu_op2_sel_o),
      .mem_op_o (mem_op_o), .wb_sel_o (wb_sel_o), .reg_wr_en_o (reg_wr_en_o),
      .rd_o (rd_o), .rs1_o (rs1_o), .rs2_o (rs2_o), .funct3_o (funct3_o),
      .funct7_o (funct7_o), .is_load_o (is_load_o), .is_store_o (is_store_o),
      .is_branch_o (is_branch_o), .is_jump_o (is_jump_o), .ex_op_o (ex_op_o),
      .stall_o (stall_o)
   );

   always #20 clk_i = ~clk_i;

   //////////////////////
   // Reference model
   //////////////////////

   function automatic mem_op_e mem_ref(input logic store, input logic [2:0] f3);
      case ({store, f3})
         4'b0_000: return LB;
         4'b0_001: return LH;
         4'b0_010: return LW;
         4'b0_100: return LBU;
         4'b0_101: return LHU;
         4'b1_000: return SB;
         4'b1_001: return SH;
         4'b1_010: return SW;
         default:  return MEM_NONE;
      endcase
   endfunction

   function automatic ctrl_t decode_ctrl(input logic [31:0] w);
      ctrl_t c;
      c = '0;
      c.alu2 = (w[6:2] != OP);  // Immediate operand for all but OP
      case (opcode_e'(w[6:2]))
         LOAD: begin
            c.wb  = WB_MEM;
            c.wr  = 1'b1;
            c.ld  = 1'b1;
            c.mem = mem_ref(1'b0, w[14:12]);
         end
         STORE: begin
            c.st  = 1'b1;
            c.mem = mem_ref(1'b1, w[14:12]);
         end
         BRANCH: begin
            c.alu1 = 1'b1;
            c.ex   = EX_BRANCH;
            c.br   = 1'b1;
         end
         JAL, JALR: begin
            c.alu1 = (w[6:2] == JAL);
            c.wb   = WB_PC4;
            c.wr   = 1'b1;
            c.jmp  = 1'b1;
         end
         OP_IMM, OP: begin
            c.wr = 1'b1;
            c.ex = EX_FUNCT;
         end
         LUI: begin
            c.wb = WB_IMM;
            c.wr = 1'b1;
            c.ex = EX_PASS;
         end
         AUIPC: begin
            c.alu1 = 1'b1;
            c.wr   = 1'b1;
         end
         default: c = '0;
      endcase
      return c;
   endfunction

   // Immediate per base ISA format of each opcode
   function automatic logic [31:0] imm_ref(input logic [31:0] w);
      case (opcode_e'(w[6:2]))
         LOAD, JALR, OP_IMM: return 32'($signed(w[31:20]));
         STORE:       return 32'($signed({w[31:25], w[11:7]}));
         BRANCH:      return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
         JAL:         return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
         LUI, AUIPC:  return {w[31:12], 12'h000};
         default:     return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] read_ref(input logic [4:0] addr);
      if (addr == 5'd0) begin
         return 32'h0;
      end else if (wb_en_i && (wb_rd_i == addr)) begin
         return wb_data_i;  // Write in the same cycle
      end
      return shadow[addr];
   endfunction

   function automatic logic stall_ref(input logic [31:0] w);
      return exp_out.c.ld && (exp_out.rd != 5'd0) &&
             ((exp_out.rd == w[19:15]) || (exp_out.rd == w[24:20]));
   endfunction

   function automatic out_t decode_out(input logic [31:0] w, input logic [31:0] pc);
      out_t o;
      o.pc   = pc;
      o.rs1v = read_ref(w[19:15]);
      o.rs2v = read_ref(w[24:20]);
      o.imm  = imm_ref(w);
      o.c    = decode_ctrl(w);
      o.rd   = w[11:7];
      o.rs1  = w[19:15];
      o.rs2  = w[24:20];
      o.f3   = w[14:12];
      o.f7   = w[31:25];
      return o;
   endfunction

   // Sees the inputs as the DUT samples them at the edge
   always @(posedge clk_i) begin
      if (reset_i) begin
         exp_out = '0;
         for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'h0;
         end
         model_valid = 1'b1;
      end else begin
         if (!busywait_i) begin
            if (flush_i || stall_ref(instr_i)) begin
               exp_out = '0;  // Bubble
            end else begin
               exp_out = decode_out(instr_i, pc_i);
            end
         end
         if (wb_en_i && (wb_rd_i != 5'd0)) begin
            shadow[wb_rd_i] = wb_data_i;
         end
      end
   end

   //////////////////////
   // Checks
   //////////////////////

   task automatic expect_eq(input logic [31:0] got, input logic [31:0] want, input string what);
      assert (got === want) else begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
         error_count++;
      end
   endtask

   always @(negedge clk_i) begin
      if (model_valid) begin
         expect_eq(pc_o, exp_out.pc, "pc_o");
         expect_eq(rs1_value_o, exp_out.rs1v, "rs1_value_o");
         expect_eq(rs2_value_o, exp_out.rs2v, "rs2_value_o");
         expect_eq(imm_o, exp_out.imm, "imm_o");
         expect_eq(alu_op1_sel_o, exp_out.c.alu1, "alu_op1_sel_o");
         expect_eq(alu_op2_sel_o, exp_out.c.alu2, "alu_op2_sel_o");
         expect_eq(mem_op_o, exp_out.c.mem, "mem_op_o");
         expect_eq(wb_sel_o, exp_out.c.wb, "wb_sel_o");
         expect_eq(reg_wr_en_o, exp_out.c.wr, "reg_wr_en_o");
         expect_eq(ex_op_o, exp_out.c.ex, "ex_op_o");
         expect_eq(is_load_o, exp_out.c.ld, "is_load_o");
         expect_eq(is_store_o, exp_out.c.st, "is_store_o");
         expect_eq(is_branch_o, exp_out.c.br, "is_branch_o");
         expect_eq(is_jump_o, exp_out.c.jmp, "is_jump_o");
         expect_eq(rd_o, exp_out.rd, "rd_o");
         expect_eq(rs1_o, exp_out.rs1, "rs1_o");
         expect_eq(rs2_o, exp_out.rs2, "rs2_o");
         expect_eq(funct3_o, exp_out.f3, "funct3_o");
         expect_eq(funct7_o, exp_out.f7, "funct7_o");
         expect_eq(stall_o, stall_ref(instr_i), "stall_o");
      end
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   //////////////////////
   // Stimulus helpers
   //////////////////////

   function automatic logic [31:0] make_instr(input opcode_e op, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [2:0] f3);
      return {7'b0000000, rs2, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] rand_instr();
      opcode_e     ops [9] = '{LOAD, STORE, BRANCH, JAL, JALR, OP_IMM, OP, LUI, AUIPC};
      logic [2:0]  load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      opcode_e     op;
      logic [31:0] w;
      op = ops[$urandom % 9];
      w = $urandom;
      w[6:0] = {op, 2'b11};
      if (op == LOAD) begin
         w[14:12] = load_f3[$urandom % 5];
      end else if (op == STORE) begin
         w[14:12] = 3'($urandom % 3);
      end
      return w;
   endfunction

   task automatic drive(input logic [31:0] w, input logic wen, input logic [4:0] wrd,
                        input logic [31:0] wdata);
      @(posedge clk_i);
      instr_i   <= w;
      pc_i      <= next_pc;
      wb_en_i   <= wen;
      wb_rd_i   <= wrd;
      wb_data_i <= wdata;
      next_pc   += 4;
      @(negedge clk_i);
   endtask

   // Plays fetch, holding the word while the stage stalls
   task automatic issue(input logic [31:0] w, input logic wen, input logic [4:0] wrd,
                        input logic [31:0] wdata);
      drive(w, wen, wrd, wdata);
      while (stall_o) begin
         @(posedge clk_i);
         wb_en_i <= 1'b0;
         @(negedge clk_i);
      end
   endtask

   function automatic logic [167:0] pack_outputs();
      return {pc_o, imm_o, rs1_value_o, rs2_value_o, rd_o, rs1_o, rs2_o, funct3_o,
              funct7_o, mem_op_o, wb_sel_o, ex_op_o, alu_op1_sel_o, alu_op2_sel_o,
              reg_wr_en_o, is_load_o, is_store_o, is_branch_o, is_jump_o};
   endfunction

   task automatic start_test();
      errors_at_start = error_count;
   endtask

   task automatic finish_test(input string name);
      repeat (2) @(posedge clk_i);  // Last word registered and checked
      if (error_count == errors_at_start) begin
         tests_passed++;
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, error_count - errors_at_start);
      end
   endtask

   //////////////////////
   // Tests
   //////////////////////

   initial begin
      logic [4:0]   r;
      logic [167:0] snap;
      void'($urandom(32'hfc22));
      reset_i    = 1'b1;
      instr_i    = NOP;
      pc_i       = 32'h0;
      wb_en_i    = 1'b0;
      wb_rd_i    = 5'd0;
      wb_data_i  = 32'h0;
      busywait_i = 1'b0;
      flush_i    = 1'b0;
      repeat (16) @(posedge clk_i);
      reset_i <= 1'b0;
      start_test();
      @(negedge clk_i);

      expect_eq(reg_wr_en_o, 1'b0, "reg_wr_en_o after reset");
      expect_eq(is_load_o | is_store_o | is_branch_o | is_jump_o, 1'b0, "flags after reset");
      expect_eq(stall_o, 1'b0, "stall_o after reset");
      expect_eq(mem_op_o, MEM_NONE, "mem_op_o after reset");
      for (int i = 0; i < 16; i++) begin
         issue(make_instr(OP, 5'd1, 5'(2 * i), 5'(2 * i + 1), 3'd0), 1'b0, 5'd0, 32'h0);
      end
      finish_test("reset state");

      start_test();
      for (int i = 0; i < 40; i++) begin
         r = 5'($urandom);
         issue(make_instr(OP, 5'd1, r, 5'($urandom), 3'd0), 1'b1, r, $urandom);
      end
      issue(make_instr(OP, 5'd1, 5'd0, 5'd17, 3'd0), 1'b1, 5'd0, 32'hdead_beef);
      issue(make_instr(OP, 5'd1, 5'd17, 5'd0, 3'd0), 1'b1, 5'd17, 32'h1234_5678);
      expect_eq(rs1_value_o, 32'h0, "x0 after write");
      issue(NOP, 1'b0, 5'd0, 32'h0);
      expect_eq(rs1_value_o, 32'h1234_5678, "same-cycle read of x17");
      for (int i = 0; i < 16; i++) begin
         issue(make_instr(OP, 5'd1, 5'(2 * i), 5'(2 * i + 1), 3'd0), 1'b0, 5'd0, 32'h0);
      end
      finish_test("register file");

      start_test();
      for (int i = 0; i < RAND_COUNT; i++) begin
         issue(rand_instr(), 1'($urandom), 5'($urandom), $urandom);
      end
      finish_test("random decode");

      start_test();
      issue(NOP, 1'b0, 5'd0, 32'h0);
      issue(NOP, 1'b0, 5'd0, 32'h0);
      drive(make_instr(LOAD, 5'd5, 5'd1, 5'd2, 3'd2), 1'b0, 5'd0, 32'h0);
      drive(make_instr(OP, 5'd7, 5'd3, 5'd5, 3'd0), 1'b0, 5'd0, 32'h0);
      expect_eq(stall_o, 1'b1, "stall_o on load-use");
      @(posedge clk_i);
      @(negedge clk_i);
      expect_eq(reg_wr_en_o, 1'b0, "reg_wr_en_o in bubble");
      expect_eq(mem_op_o, MEM_NONE, "mem_op_o in bubble");
      expect_eq(stall_o, 1'b0, "stall_o after bubble");
      @(posedge clk_i);
      @(negedge clk_i);
      expect_eq(rd_o, 5'd7, "rd_o of held instruction");
      drive(make_instr(LOAD, 5'd0, 5'd1, 5'd2, 3'd2), 1'b0, 5'd0, 32'h0);
      drive(make_instr(OP, 5'd8, 5'd0, 5'd0, 3'd0), 1'b0, 5'd0, 32'h0);
      expect_eq(stall_o, 1'b0, "stall_o on load to x0");
      drive(make_instr(LOAD, 5'd9, 5'd1, 5'd2, 3'd0), 1'b0, 5'd0, 32'h0);
      drive(make_instr(OP, 5'd10, 5'd3, 5'd4, 3'd0), 1'b0, 5'd0, 32'h0);
      expect_eq(stall_o, 1'b0, "stall_o without matching source");
      finish_test("load-use hazard");

      start_test();
      issue(NOP, 1'b0, 5'd0, 32'h0);
      @(posedge clk_i);
      instr_i <= make_instr(JAL, 5'd8, 5'd0, 5'd0, 3'd0);
      flush_i <= 1'b1;
      @(posedge clk_i);
      flush_i <= 1'b0;
      @(negedge clk_i);
      expect_eq(is_jump_o, 1'b0, "is_jump_o after flush");
      expect_eq(reg_wr_en_o, 1'b0, "reg_wr_en_o after flush");
      expect_eq(pc_o, 32'h0, "pc_o after flush");
      finish_test("flush");

      start_test();
      issue(make_instr(LUI, 5'd11, 5'd3, 5'd9, 3'd5), 1'b0, 5'd0, 32'h0);
      @(posedge clk_i);  // LUI enters the register here
      instr_i    <= make_instr(OP, 5'd13, 5'd12, 5'd0, 3'd0);
      busywait_i <= 1'b1;
      flush_i    <= 1'b1;
      wb_en_i    <= 1'b1;
      wb_rd_i    <= 5'd12;
      wb_data_i  <= 32'hcafe_0012;
      @(negedge clk_i);
      snap = pack_outputs();
      @(posedge clk_i);
      wb_en_i <= 1'b0;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      assert (pack_outputs() === snap) else begin
         $display("ERR %0t: outputs changed while busywait was high", $time);
         error_count++;
      end
      @(posedge clk_i);
      busywait_i <= 1'b0;
      flush_i    <= 1'b0;
      @(posedge clk_i);
      @(negedge clk_i);
      expect_eq(rs1_value_o, 32'hcafe_0012, "write-back during busywait");
      finish_test("busywait");

      $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
               tests_passed, tests_failed, error_count);
      if ((tests_failed == 0) && (error_count == 0)) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
